// File: src/lv_pkg.sv
/*
  shared types for the LV control die
  register bus is 7-bit address and 8-bit data
  struct field order fixes the register bit layout, msb first
*/
package lv_pkg;

    localparam int REG_AW      = 7;
    localparam int REG_DW      = 8;
    localparam int SPI_FRAME_W = 16;    // rw bit, address, data

    typedef logic [REG_AW-1:0] reg_addr_t;
    typedef logic [REG_DW-1:0] reg_data_t;

    // ====================
    // register map
    localparam reg_addr_t ADDR_MODE    = 7'h00;
    localparam reg_addr_t ADDR_CONFIG  = 7'h01;
    localparam reg_addr_t ADDR_STATUS1 = 7'h02;
    localparam reg_addr_t ADDR_STATUS2 = 7'h03;
    localparam reg_addr_t ADDR_STATE   = 7'h04;

    typedef struct packed {
        logic      wr;      // one-cycle strobe
        logic      rd;      // one-cycle strobe
        reg_addr_t addr;
        reg_data_t wdata;
    } reg_req_t;

    typedef struct packed {
        logic reset_en;     // self clearing
        logic normal_en;
        logic cfg_en;
    } mode_t;

    typedef struct packed {
        logic       rtmon;
        logic [2:0] vge_mon_dly;    // mismatch filter, cycles
    } config_t;

    // sticky, write 1 to clear
    typedef struct packed {
        logic pwm_mmerr;
        logic pwm_dterr;
        logic spi_err;
    } status1_t;

    typedef struct packed {
        logic mmerr;        // pulse
        logic dterr;        // pulse
        logic fsenb_n;
        logic vsup_uv;      // active high here
        logic vsup_ov;
    } pin_flags_t;

    typedef enum logic [1:0] {
        ST_WAIT   = 2'd0,
        ST_CFG    = 2'd1,
        ST_NORMAL = 2'd2,
        ST_FAULT  = 2'd3
    } ctrl_st_e;

endpackage

// File: src/spi_slv.sv
/*
  SPI mode 0 slave, oversampled in the i_clk domain
  frame is 16 bits msb first: rw, addr[6:0], data[7:0]
  SCLK half period must be at least SYNC_STAGES+3 i_clk cycles
  any frame that is not exactly 16 bits raises o_frame_err, no write
*/
`timescale 1ns/1ps

module spi_slv #(
    parameter int SYNC_STAGES = 2
) (
    input  logic              i_clk,
    input  logic              i_arst_n,
    input  logic              i_spi_sclk,
    input  logic              i_spi_csb,
    input  logic              i_spi_mosi,
    output logic              o_spi_miso,
    input  lv_pkg::reg_data_t i_rdata,
    output lv_pkg::reg_req_t  o_req,
    output logic              o_frame_err
);

    localparam int FW       = lv_pkg::SPI_FRAME_W;
    localparam int DW       = lv_pkg::REG_DW;
    localparam int CNT_W    = $clog2(FW) + 1;
    localparam int HDR_BITS = FW - DW;
    localparam logic [2:0] PIN_RST = 3'b010;    // {sclk, csb, mosi}, csb idles high

    logic [SYNC_STAGES-1:0][2:0] pin_sync;
    logic                        sclk_s;
    logic                        csb_s;
    logic                        mosi_s;
    logic                        sclk_d;
    logic                        csb_d;
    logic                        sclk_rise;
    logic                        sclk_fall;
    logic                        csb_rise;
    logic [CNT_W-1:0]            bit_cnt;
    logic [FW-1:0]               frame_q;
    lv_pkg::reg_data_t           tx_sh;
    logic                        rd_stb;
    logic                        wr_stb;
    logic                        err_stb;

    // ====================
    // pin sync and edges
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pin_sync <= {SYNC_STAGES{PIN_RST}};
            sclk_d   <= 1'b0;
            csb_d    <= 1'b1;
        end else begin
            pin_sync <= {pin_sync[SYNC_STAGES-2:0], {i_spi_sclk, i_spi_csb, i_spi_mosi}};
            sclk_d   <= sclk_s;
            csb_d    <= csb_s;
        end
    end

    assign {sclk_s, csb_s, mosi_s} = pin_sync[SYNC_STAGES-1];
    assign sclk_rise = sclk_s & ~sclk_d;
    assign sclk_fall = ~sclk_s & sclk_d;
    assign csb_rise  = csb_s & ~csb_d;

    // ====================
    // bit count and strobes
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            bit_cnt <= '0;
            rd_stb  <= 1'b0;
            wr_stb  <= 1'b0;
            err_stb <= 1'b0;
        end else begin
            rd_stb  <= 1'b0;
            wr_stb  <= csb_rise && (bit_cnt == CNT_W'(FW)) && frame_q[FW-1];
            err_stb <= csb_rise && (bit_cnt != CNT_W'(FW));
            if (csb_s) begin
                bit_cnt <= '0;
            end else if (sclk_rise) begin
                if (bit_cnt != '1) begin
                    bit_cnt <= bit_cnt + 1'b1;     // saturates on long frames
                end
                // 8th bit arriving, rw bit sits at frame_q[6]
                rd_stb <= (bit_cnt == CNT_W'(HDR_BITS - 1)) && !frame_q[HDR_BITS-2];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (sclk_rise && !csb_s) begin
            frame_q <= {frame_q[FW-2:0], mosi_s};
        end
    end

    // read data goes out on the falls after the 8th bit
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            tx_sh <= '0;
        end else if (csb_s) begin
            tx_sh <= '0;
        end else if (sclk_fall) begin
            if (bit_cnt == CNT_W'(HDR_BITS) && !frame_q[HDR_BITS-1]) begin
                tx_sh <= i_rdata;
            end else begin
                tx_sh <= {tx_sh[DW-2:0], 1'b0};
            end
        end
    end

    assign o_spi_miso = tx_sh[DW-1];

    always_comb begin
        o_req.wr    = wr_stb;
        o_req.rd    = rd_stb;
        o_req.addr  = rd_stb ? frame_q[lv_pkg::REG_AW-1:0]
                             : frame_q[FW-2 -: lv_pkg::REG_AW];
        o_req.wdata = frame_q[DW-1:0];
    end

    assign o_frame_err = err_stb;

endmodule

// File: src/lv_reg_slv.sv
/*
  register file behind the SPI slave
  CONFIG accepts writes only while i_cfg_wr_en is high
  STATUS1 is sticky, write 1 clears, a new error in the same cycle wins
  read data is valid one cycle after the read strobe
  unmapped addresses read 0 and ignore writes
*/
`timescale 1ns/1ps

module lv_reg_slv (
    input  logic               i_clk,
    input  logic               i_arst_n,
    input  lv_pkg::reg_req_t   i_req,
    input  logic               i_frame_err,
    input  lv_pkg::pin_flags_t i_pins,
    input  logic               i_cfg_wr_en,
    input  lv_pkg::ctrl_st_e   i_state,
    output lv_pkg::reg_data_t  o_rdata,
    output lv_pkg::mode_t      o_mode,
    output lv_pkg::config_t    o_config,
    output lv_pkg::status1_t   o_status1
);

    localparam int MODE_W = $bits(lv_pkg::mode_t);
    localparam int CFG_W  = $bits(lv_pkg::config_t);
    localparam int ST1_W  = $bits(lv_pkg::status1_t);

    lv_pkg::mode_t     mode_q;
    lv_pkg::config_t   cfg_q;
    lv_pkg::status1_t  st1_q;
    lv_pkg::status1_t  st1_set;
    lv_pkg::status1_t  st1_clr;
    lv_pkg::reg_data_t rd_mux;
    lv_pkg::reg_data_t rdata_q;
    logic              wr_mode;
    logic              wr_cfg;
    logic              wr_st1;

    assign wr_mode = i_req.wr && (i_req.addr == lv_pkg::ADDR_MODE);
    assign wr_cfg  = i_req.wr && (i_req.addr == lv_pkg::ADDR_CONFIG) && i_cfg_wr_en;
    assign wr_st1  = i_req.wr && (i_req.addr == lv_pkg::ADDR_STATUS1);

    always_comb begin
        st1_set.pwm_mmerr = i_pins.mmerr;
        st1_set.pwm_dterr = i_pins.dterr;
        st1_set.spi_err   = i_frame_err;
    end

    assign st1_clr = wr_st1 ? lv_pkg::status1_t'(i_req.wdata[ST1_W-1:0]) : '0;

    // ====================
    // control registers
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            mode_q <= '0;
            cfg_q  <= '0;
            st1_q  <= '0;
        end else begin
            if (wr_mode) begin
                mode_q <= lv_pkg::mode_t'(i_req.wdata[MODE_W-1:0]);
            end else begin
                mode_q.reset_en <= 1'b0;   // one cycle only
            end
            if (wr_cfg) begin
                cfg_q <= lv_pkg::config_t'(i_req.wdata[CFG_W-1:0]);
            end
            st1_q <= (st1_q & ~st1_clr) | st1_set;
        end
    end

    // ====================
    // read path
    always_comb begin
        unique case (i_req.addr)
            lv_pkg::ADDR_MODE:    rd_mux = lv_pkg::reg_data_t'(mode_q);
            lv_pkg::ADDR_CONFIG:  rd_mux = lv_pkg::reg_data_t'(cfg_q);
            lv_pkg::ADDR_STATUS1: rd_mux = lv_pkg::reg_data_t'(st1_q);
            lv_pkg::ADDR_STATUS2: rd_mux = lv_pkg::reg_data_t'({i_pins.vsup_ov, i_pins.vsup_uv});
            lv_pkg::ADDR_STATE:   rd_mux = lv_pkg::reg_data_t'(i_state);
            default:              rd_mux = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_req.rd) begin
            rdata_q <= rd_mux;
        end
    end

    assign o_rdata   = rdata_q;
    assign o_mode    = mode_q;
    assign o_config  = cfg_q;
    assign o_status1 = st1_q;

endmodule

// File: src/lv_ctrl_unit.sv
/*
  control FSM of the LV die: wait, cfg, normal, fault
  fault is left only through the reset_en strobe in MODE
  outputs decode directly from the state register
*/
`timescale 1ns/1ps

module lv_ctrl_unit (
    input  logic               i_clk,
    input  logic               i_arst_n,
    input  lv_pkg::mode_t      i_mode,
    input  lv_pkg::status1_t   i_status1,
    input  lv_pkg::pin_flags_t i_pins,
    output lv_pkg::ctrl_st_e   o_state,
    output logic               o_cfg_wr_en,
    output logic               o_pwm_en,
    output logic               o_fsc_en,
    output logic               o_intb_n
);

    lv_pkg::ctrl_st_e state_q;
    lv_pkg::ctrl_st_e state_nxt;
    logic             fault_det;

    // any sticky error or a live supply / fail-safe flag
    assign fault_det = (|i_status1) || i_pins.vsup_uv || i_pins.vsup_ov || !i_pins.fsenb_n;

    // ====================
    // next state
    always_comb begin
        state_nxt = state_q;
        unique case (state_q)
            lv_pkg::ST_WAIT: begin
                if (i_mode.cfg_en) begin
                    state_nxt = lv_pkg::ST_CFG;
                end
            end
            lv_pkg::ST_CFG: begin
                if (i_mode.normal_en && !i_mode.cfg_en) begin
                    state_nxt = lv_pkg::ST_NORMAL;
                end
            end
            lv_pkg::ST_NORMAL: begin
                if (fault_det) begin
                    state_nxt = lv_pkg::ST_FAULT;
                end
            end
            lv_pkg::ST_FAULT: begin
                if (i_mode.reset_en) begin
                    state_nxt = lv_pkg::ST_WAIT;
                end
            end
            default: state_nxt = lv_pkg::ST_WAIT;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= lv_pkg::ST_WAIT;
        end else begin
            state_q <= state_nxt;
        end
    end

    // ====================
    // output decode
    assign o_state     = state_q;
    assign o_cfg_wr_en = (state_q == lv_pkg::ST_CFG);
    assign o_pwm_en    = (state_q == lv_pkg::ST_NORMAL);
    assign o_fsc_en    = (state_q == lv_pkg::ST_FAULT);    // clamp on in fault
    assign o_intb_n    = (state_q != lv_pkg::ST_FAULT);

endmodule

// File: src/lv_analog_int_proc.sv
/*
  synchronizes the analog-die flags into the i_clk domain
  mismatch error fires once per episode after vge_mon_dly+1 high cycles
  dead-time error fires on every synchronized rising edge
*/
`timescale 1ns/1ps

module lv_analog_int_proc #(
    parameter int SYNC_STAGES = 2
) (
    input  logic               i_clk,
    input  logic               i_arst_n,
    input  logic               i_lv_vsup_ov,
    input  logic               i_lv_vsup_uv_n,
    input  logic               i_lv_pwm_dt,
    input  logic               i_lv_gate_vs_pwm,
    input  logic               i_io_fsenb_n,
    input  logic [2:0]         i_vge_mon_dly,
    output lv_pkg::pin_flags_t o_pins
);

    // {ov, uv_n, dt, mm, fsenb_n}, active-low pins idle high
    localparam logic [4:0] PIN_RST = 5'b01001;

    logic [SYNC_STAGES-1:0][4:0] pin_sync;
    logic                        ov_s;
    logic                        uv_n_s;
    logic                        dt_s;
    logic                        mm_s;
    logic                        fsenb_n_s;
    logic                        dt_d;
    logic [2:0]                  mm_cnt;
    logic                        mm_done;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pin_sync <= {SYNC_STAGES{PIN_RST}};
            dt_d     <= 1'b0;
            mm_cnt   <= '0;
            mm_done  <= 1'b0;
        end else begin
            pin_sync <= {pin_sync[SYNC_STAGES-2:0],
                         {i_lv_vsup_ov, i_lv_vsup_uv_n, i_lv_pwm_dt, i_lv_gate_vs_pwm,
                          i_io_fsenb_n}};
            dt_d <= dt_s;
            if (!mm_s) begin
                mm_cnt  <= '0;
                mm_done <= 1'b0;
            end else if (!mm_done) begin
                if (mm_cnt == i_vge_mon_dly) begin
                    mm_done <= 1'b1;         // hold until flag drops
                end else begin
                    mm_cnt <= mm_cnt + 1'b1;
                end
            end
        end
    end

    assign {ov_s, uv_n_s, dt_s, mm_s, fsenb_n_s} = pin_sync[SYNC_STAGES-1];

    always_comb begin
        o_pins.vsup_ov = ov_s;
        o_pins.vsup_uv = ~uv_n_s;
        o_pins.fsenb_n = fsenb_n_s;
        o_pins.dterr   = dt_s & ~dt_d;
        o_pins.mmerr   = mm_s & ~mm_done & (mm_cnt == i_vge_mon_dly);
    end

endmodule

// File: src/lv_core.sv
/*
  LV control die top: SPI slave, register file, control FSM, analog flags
  SYNC_STAGES is 2 or 3 and sets the pin synchronizer depth
  a register write lands within SYNC_STAGES+3 cycles of CSB rise
*/
`timescale 1ns/1ps

module lv_core #(
    parameter int SYNC_STAGES = 2
) (
    input  logic i_clk,
    input  logic i_arst_n,
    input  logic i_spi_sclk,
    input  logic i_spi_csb,
    input  logic i_spi_mosi,
    output logic o_spi_miso,
    input  logic i_lv_vsup_ov,
    input  logic i_lv_vsup_uv_n,
    input  logic i_lv_pwm_dt,
    input  logic i_lv_gate_vs_pwm,
    input  logic i_io_fsenb_n,
    output logic o_dgt_ang_pwm_en,
    output logic o_dgt_ang_fsc_en,
    output logic o_intb_n,
    output logic o_rtmon
);

    lv_pkg::reg_req_t   spi_req;
    logic               spi_frame_err;
    lv_pkg::reg_data_t  reg_rdata;
    lv_pkg::pin_flags_t pins;
    lv_pkg::mode_t      reg_mode;
    lv_pkg::config_t    reg_config;
    lv_pkg::status1_t   reg_status1;
    lv_pkg::ctrl_st_e   ctrl_state;
    logic               cfg_wr_en;

    spi_slv #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_spi_slv (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_spi_sclk  (i_spi_sclk),
        .i_spi_csb   (i_spi_csb),
        .i_spi_mosi  (i_spi_mosi),
        .o_spi_miso  (o_spi_miso),
        .i_rdata     (reg_rdata),
        .o_req       (spi_req),
        .o_frame_err (spi_frame_err)
    );

    lv_reg_slv u_lv_reg_slv (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_req       (spi_req),
        .i_frame_err (spi_frame_err),
        .i_pins      (pins),
        .i_cfg_wr_en (cfg_wr_en),
        .i_state     (ctrl_state),
        .o_rdata     (reg_rdata),
        .o_mode      (reg_mode),
        .o_config    (reg_config),
        .o_status1   (reg_status1)
    );

    lv_ctrl_unit u_lv_ctrl_unit (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_mode      (reg_mode),
        .i_status1   (reg_status1),
        .i_pins      (pins),
        .o_state     (ctrl_state),
        .o_cfg_wr_en (cfg_wr_en),
        .o_pwm_en    (o_dgt_ang_pwm_en),
        .o_fsc_en    (o_dgt_ang_fsc_en),
        .o_intb_n    (o_intb_n)
    );

    lv_analog_int_proc #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_lv_analog_int_proc (
        .i_clk            (i_clk),
        .i_arst_n         (i_arst_n),
        .i_lv_vsup_ov     (i_lv_vsup_ov),
        .i_lv_vsup_uv_n   (i_lv_vsup_uv_n),
        .i_lv_pwm_dt      (i_lv_pwm_dt),
        .i_lv_gate_vs_pwm (i_lv_gate_vs_pwm),
        .i_io_fsenb_n     (i_io_fsenb_n),
        .i_vge_mon_dly    (reg_config.vge_mon_dly),
        .o_pins           (pins)
    );

    assign o_rtmon = reg_config.rtmon;    // straight from CONFIG bit 3

endmodule

// File: tb/lv_core_checker.sv
/*
  bound into lv_ctrl_unit
  checks that the FSM output decode agrees with the state
  checks are off while reset is asserted
*/
`timescale 1ns/1ps

module lv_core_checker (
    input logic             i_clk,
    input logic             i_arst_n,
    input lv_pkg::ctrl_st_e i_state,
    input logic             i_pwm_en,
    input logic             i_fsc_en,
    input logic             i_intb_n
);

    a_pwm_fsc_excl : assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(i_pwm_en && i_fsc_en))
        else $error("pwm_en and fsc_en high together");

    a_intb_fault : assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (!i_intb_n) == (i_state == lv_pkg::ST_FAULT))
        else $error("intb_n low does not match fault state");

    a_pwm_normal : assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_pwm_en == (i_state == lv_pkg::ST_NORMAL))
        else $error("pwm_en does not match normal state");

endmodule

bind lv_ctrl_unit lv_core_checker u_lv_core_checker (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_state  (o_state),
    .i_pwm_en (o_pwm_en),
    .i_fsc_en (o_fsc_en),
    .i_intb_n (o_intb_n)
);

// File: tb/lv_core_tb.sv
/*
  directed tests for the LV control die top level
  inputs change on the falling clock edge, SCLK half period is 8 clocks
  stops at the first mismatch, run limited by a cycle counter
*/
`timescale 1ns/1ps

module lv_core_tb;

    localparam int HALF_CYC   = 8;      // clocks per SCLK half period
    localparam int POST_CYC   = 10;     // write lands within SYNC_STAGES+3
    localparam int RST_CYC    = 8;
    localparam int MAX_CYCLES = 20000;  // ~45 frames of ~282 clocks plus pulses and margin

    logic clk;
    logic arst_n;
    logic spi_sclk;
    logic spi_csb;
    logic spi_mosi;
    logic o_spi_miso;
    logic lv_vsup_ov;
    logic lv_vsup_uv_n;
    logic lv_pwm_dt;
    logic lv_gate_vs_pwm;
    logic io_fsenb_n;
    logic o_dgt_ang_pwm_en;
    logic o_dgt_ang_fsc_en;
    logic o_intb_n;
    logic o_rtmon;

    int          cyc_cnt = 0;
    logic [31:0] rng_state = 32'h8dc3;
    logic [7:0]  cfg_exp;               // expected CONFIG contents

    lv_core #(.SYNC_STAGES(2)) i_lv_core (
        .i_clk (clk), .i_arst_n (arst_n),
        .i_spi_sclk (spi_sclk), .i_spi_csb (spi_csb), .i_spi_mosi (spi_mosi),
        .o_spi_miso (o_spi_miso),
        .i_lv_vsup_ov (lv_vsup_ov), .i_lv_vsup_uv_n (lv_vsup_uv_n),
        .i_lv_pwm_dt (lv_pwm_dt), .i_lv_gate_vs_pwm (lv_gate_vs_pwm),
        .i_io_fsenb_n (io_fsenb_n),
        .o_dgt_ang_pwm_en (o_dgt_ang_pwm_en), .o_dgt_ang_fsc_en (o_dgt_ang_fsc_en),
        .o_intb_n (o_intb_n), .o_rtmon (o_rtmon)
    );

    always #50 clk = ~clk;

    // ====================
    // helpers
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= MAX_CYCLES) begin
            $display("timeout: no result after %0d clock cycles", MAX_CYCLES);
            abort_run();
        end
    end

    task automatic check_val(input string name, input logic [7:0] exp, input logic [7:0] act);
        assert (act === exp) else begin
            $display("** Error at %0t ns: %s expected 0x%02h, got 0x%02h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic check_outputs(input logic pwm, input logic fsc, input logic intb_n);
        check_val("o_dgt_ang_pwm_en", {7'h0, pwm}, {7'h0, o_dgt_ang_pwm_en});
        check_val("o_dgt_ang_fsc_en", {7'h0, fsc}, {7'h0, o_dgt_ang_fsc_en});
        check_val("o_intb_n", {7'h0, intb_n}, {7'h0, o_intb_n});
    endtask

    task automatic wait_for_fault(input int limit);
        int n;
        n = 0;
        while (o_intb_n !== 1'b0 && n < limit) begin
            @(negedge clk);
            n++;
        end
        assert (o_intb_n === 1'b0) else begin
            $display("state machine did not enter fault within %0d cycles", limit);
            abort_run();
        end
    endtask

    // ====================
    // SPI master
    task automatic spi_xfer(input logic [15:0] frame, input int nbits, output logic [7:0] rbyte);
        rbyte = '0;
        @(negedge clk);
        spi_csb = 1'b0;
        wait_cycles(HALF_CYC);
        for (int i = 0; i < nbits; i++) begin
            spi_sclk = 1'b0;
            spi_mosi = frame[15-i];
            wait_cycles(HALF_CYC);
            if (i >= 8 && !frame[15]) begin
                rbyte = {rbyte[6:0], o_spi_miso};   // read data, msb first
            end else begin
                check_val("o_spi_miso", 8'h00, {7'h0, o_spi_miso});
            end
            spi_sclk = 1'b1;
            wait_cycles(HALF_CYC);
        end
        spi_sclk = 1'b0;
        spi_mosi = 1'b0;
        wait_cycles(HALF_CYC);
        spi_csb = 1'b1;
        wait_cycles(POST_CYC);
        check_val("o_spi_miso", 8'h00, {7'h0, o_spi_miso});
    endtask

    task automatic spi_write(input logic [6:0] addr, input logic [7:0] data);
        logic [7:0] unused;
        spi_xfer({1'b1, addr, data}, 16, unused);
    endtask

    task automatic spi_read(input logic [6:0] addr, output logic [7:0] data);
        spi_xfer({1'b0, addr, 8'h00}, 16, data);
    endtask

    task automatic spi_short_frame(input logic [6:0] addr, input logic [7:0] data,
                                   input int nbits);
        logic [7:0] unused;
        spi_xfer({1'b1, addr, data}, nbits, unused);
    endtask

    task automatic read_check(input logic [6:0] addr, input string name, input logic [7:0] exp);
        logic [7:0] got;
        spi_read(addr, got);
        check_val(name, exp, got);
    endtask

    task automatic enter_normal();
        spi_write(lv_pkg::ADDR_MODE, 8'h01);    // cfg_en
        read_check(lv_pkg::ADDR_STATE, "STATE", 8'h01);
        spi_write(lv_pkg::ADDR_MODE, 8'h02);    // normal_en
        read_check(lv_pkg::ADDR_STATE, "STATE", 8'h02);
        check_outputs(1'b1, 1'b0, 1'b1);
    endtask

    task automatic leave_fault();
        spi_write(lv_pkg::ADDR_MODE, 8'h04);    // reset_en
        read_check(lv_pkg::ADDR_STATE, "STATE", 8'h00);
        check_outputs(1'b0, 1'b0, 1'b1);
    endtask

    // ====================
    // tests
    task automatic test_reset();
        check_outputs(1'b0, 1'b0, 1'b1);
        check_val("o_spi_miso", 8'h00, {7'h0, o_spi_miso});
        check_val("o_rtmon", 8'h00, {7'h0, o_rtmon});
        read_check(lv_pkg::ADDR_MODE, "MODE", 8'h00);
        read_check(lv_pkg::ADDR_CONFIG, "CONFIG", 8'h00);
        read_check(lv_pkg::ADDR_STATUS1, "STATUS1", 8'h00);
        read_check(lv_pkg::ADDR_STATE, "STATE", 8'h00);
    endtask

    task automatic test_reg_access();
        rng_state = xorshift32(rng_state);
        spi_write(lv_pkg::ADDR_CONFIG, rng_state[7:0]);     // ignored outside cfg
        read_check(lv_pkg::ADDR_CONFIG, "CONFIG", 8'h00);
        spi_write(lv_pkg::ADDR_MODE, 8'h01);
        read_check(lv_pkg::ADDR_STATE, "STATE", 8'h01);
        rng_state = xorshift32(rng_state);
        cfg_exp = rng_state[7:0] & 8'h0f;
        spi_write(lv_pkg::ADDR_CONFIG, rng_state[7:0]);
        read_check(lv_pkg::ADDR_CONFIG, "CONFIG", cfg_exp);
        check_val("o_rtmon", {7'h0, cfg_exp[3]}, {7'h0, o_rtmon});
        // second value keeps a filter delay of 3 for the mismatch test
        rng_state = xorshift32(rng_state);
        cfg_exp = (rng_state[7:0] & 8'h08) | 8'h03;
        spi_write(lv_pkg::ADDR_CONFIG, (rng_state[7:0] & 8'hf8) | 8'h03);
        read_check(lv_pkg::ADDR_CONFIG, "CONFIG", cfg_exp);
        check_val("o_rtmon", {7'h0, cfg_exp[3]}, {7'h0, o_rtmon});
        read_check(7'h55, "unmapped 0x55", 8'h00);
        read_check(lv_pkg::ADDR_MODE, "MODE", 8'h01);
    endtask

    task automatic test_normal_entry();
        spi_write(lv_pkg::ADDR_MODE, 8'h02);
        check_outputs(1'b1, 1'b0, 1'b1);
        read_check(lv_pkg::ADDR_STATE, "STATE", 8'h02);
    endtask

    task automatic test_mismatch_filter();
        int dly;
        dly = int'(cfg_exp[2:0]);
        lv_gate_vs_pwm = 1'b1;
        wait_cycles(dly);           // one cycle short of the filter
        lv_gate_vs_pwm = 1'b0;
        wait_cycles(6);
        read_check(lv_pkg::ADDR_STATUS1, "STATUS1", 8'h00);
        check_outputs(1'b1, 1'b0, 1'b1);
        lv_gate_vs_pwm = 1'b1;
        wait_for_fault(dly + 10);
        lv_gate_vs_pwm = 1'b0;
        check_outputs(1'b0, 1'b1, 1'b0);
        read_check(lv_pkg::ADDR_STATUS1, "STATUS1", 8'h04);
        spi_write(lv_pkg::ADDR_STATUS1, 8'h04);
        read_check(lv_pkg::ADDR_STATUS1, "STATUS1", 8'h00);
        leave_fault();
        read_check(lv_pkg::ADDR_MODE, "MODE", 8'h00);
    endtask

    task automatic test_framing_dt();
        spi_write(lv_pkg::ADDR_MODE, 8'h02);    // normal_en alone keeps WAIT
        spi_short_frame(lv_pkg::ADDR_MODE, 8'h01, 12);
        read_check(lv_pkg::ADDR_MODE, "MODE", 8'h02);
        read_check(lv_pkg::ADDR_STATUS1, "STATUS1", 8'h01);
        lv_pwm_dt = 1'b1;
        wait_cycles(3);
        lv_pwm_dt = 1'b0;
        wait_cycles(6);
        read_check(lv_pkg::ADDR_STATUS1, "STATUS1", 8'h03);
        spi_write(lv_pkg::ADDR_STATUS1, 8'h03);
        read_check(lv_pkg::ADDR_STATUS1, "STATUS1", 8'h00);
        read_check(lv_pkg::ADDR_STATE, "STATE", 8'h00);
    endtask

    task automatic test_pin_faults();
        enter_normal();
        lv_vsup_uv_n = 1'b0;
        wait_for_fault(10);
        read_check(lv_pkg::ADDR_STATUS2, "STATUS2", 8'h01);
        read_check(lv_pkg::ADDR_STATE, "STATE", 8'h03);
        lv_vsup_uv_n = 1'b1;
        wait_cycles(4);
        leave_fault();
        enter_normal();
        io_fsenb_n = 1'b0;
        wait_for_fault(10);
        read_check(lv_pkg::ADDR_STATUS2, "STATUS2", 8'h00);
        read_check(lv_pkg::ADDR_STATE, "STATE", 8'h03);
        io_fsenb_n = 1'b1;
        wait_cycles(4);
        leave_fault();
    endtask

    initial begin
        clk            = 1'b0;
        arst_n         = 1'b0;
        spi_sclk       = 1'b0;
        spi_csb        = 1'b1;
        spi_mosi       = 1'b0;
        lv_vsup_ov     = 1'b0;
        lv_vsup_uv_n   = 1'b1;
        lv_pwm_dt      = 1'b0;
        lv_gate_vs_pwm = 1'b0;
        io_fsenb_n     = 1'b1;
        cfg_exp        = 8'h00;
        wait_cycles(RST_CYC);
        arst_n = 1'b1;
        wait_cycles(2);
        test_reset();
        test_reg_access();
        test_normal_entry();
        test_mismatch_filter();
        test_framing_dt();
        test_pin_faults();
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: flist.f
src/lv_pkg.sv
src/spi_slv.sv
src/lv_reg_slv.sv
src/lv_ctrl_unit.sv
src/lv_analog_int_proc.sv
src/lv_core.sv
tb/lv_core_checker.sv
tb/lv_core_tb.sv

// File: run.sh
#!/bin/sh
# build and run the LV core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module lv_core_tb \
    -f flist.f \
    -o sim_lv_core

./obj_dir/sim_lv_core > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failures found" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "All tests passed!" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
